//--- fmc_apb_top.f
rtl/fmc_apb_pkg.sv
rtl/apb_if.sv
rtl/fmc_apb_bridge.sv
rtl/apb_decoder.sv
rtl/apb_scratch_ram.sv
rtl/apb_status_regs.sv
rtl/fmc_apb_top.sv
tb/fmc_clock_gen.sv
tb/tb_fmc_apb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the FMC to APB testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--timescale 1ns/1ps \
	--top-module tb_fmc_apb_top \
	--Mdir obj_dir \
	-f fmc_apb_top.f

# A failing run exits nonzero, the search below decides the result
sim_out="$(./obj_dir/Vtb_fmc_apb_top 2>&1)" || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "test passed"; then
	exit 0
else
	echo "simulation did not report success" >&2
	exit 1
fi

//--- tb/tb_fmc_apb_top.sv
`timescale 1ns/1ps

module tb_fmc_apb_top;

	localparam int wait_rtt    = 2;
	localparam int depth_words = 256;
	// Clocks allowed for any single wait on the DUT
	localparam int wait_limit  = 50;

	logic        apb;
	logic        arst_n;
	logic        cs_n;
	logic        nadv_n;
	logic        nwe_n;
	logic        noe_n;
	logic [1:0]  nbl_n;
	logic [2:0]  a_hi;
	logic [15:0] ad_in;
	logic [15:0] ad_out;
	logic        ad_oe_n;
	logic        nwait;

	integer seed = 32'h3498_3f8c;
	string  test_name;
	int     issued;
	int     checked;

	// Shadow state of everything readable
	logic [fmc_apb_pkg::data_width-1:0] ram_model [depth_words];
	logic [fmc_apb_pkg::data_width-1:0] scratch_model;
	logic [fmc_apb_pkg::data_width-1:0] miss_model;

	// Pending reads, filled by the FMC model and drained by the compare process
	logic [fmc_apb_pkg::data_width-1:0] exp_q [$];
	logic [fmc_apb_pkg::data_width-1:0] got_q [$];
	string                              name_q [$];

	logic [fmc_apb_pkg::data_width-1:0] cmp_exp;
	logic [fmc_apb_pkg::data_width-1:0] cmp_got;
	string                              cmp_name;

	fmc_clock_gen u_clk (
		.apb    (apb),
		.arst_n (arst_n)
	);

	fmc_apb_top #(
		.wait_rtt    (wait_rtt),
		.depth_words (depth_words)
	) u_dut (
		.apb     (apb),
		.arst_n  (arst_n),
		.cs_n    (cs_n),
		.nadv_n  (nadv_n),
		.nwe_n   (nwe_n),
		.noe_n   (noe_n),
		.nbl_n   (nbl_n),
		.a_hi    (a_hi),
		.ad_in   (ad_in),
		.ad_out  (ad_out),
		.ad_oe_n (ad_oe_n),
		.nwait   (nwait)
	);

	//////////////////////////////////////////////////////////////////////
	// Reference model

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
		input logic [31:0] data, input logic [3:0] strb);
		logic [31:0] word;
		word = old_word;
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				word[8*b +: 8] = data[8*b +: 8];
		end
		return word;
	endfunction

	// Expected read data for a byte address
	function automatic logic [31:0] ref_read(input logic [19:0] addr);
		logic [31:0] word;
		int          idx;
		idx = int'(addr >> 2) % depth_words;
		case (addr[19:16])
			4'h0: word = ram_model[idx];
			4'h1: begin
				case (addr[3:0])
					fmc_apb_pkg::reg_id:         word = fmc_apb_pkg::id_value;
					fmc_apb_pkg::reg_miss_count: word = miss_model;
					fmc_apb_pkg::reg_scratch:    word = scratch_model;
					default:                     word = '0;
				endcase
			end
			default: word = fmc_apb_pkg::miss_rdata;
		endcase
		return word;
	endfunction

	// Effect of a write on the shadow state
	function automatic void model_write(input logic [19:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		int idx;
		idx = int'(addr >> 2) % depth_words;
		case (addr[19:16])
			4'h0: ram_model[idx] = merge_bytes(ram_model[idx], data, strb);
			4'h1: begin
				// ID and miss count are read-only
				if (addr[3:0] == fmc_apb_pkg::reg_scratch)
					scratch_model = merge_bytes(scratch_model, data, strb);
			end
			default: begin
				if (miss_model != '1)
					miss_model = miss_model + 32'd1;
			end
		endcase
	endfunction

	function automatic logic [19:0] pick_ram_addr();
		logic [31:0] r;
		r = $random(seed);
		return {4'h0, r[15:2], 2'b00};
	endfunction

	// Any region nibble from 2 up is unmapped
	function automatic logic [19:0] pick_miss_addr();
		logic [31:0] r;
		logic [3:0]  nib;
		r   = $random(seed);
		nib = 4'h2 + 4'(r[31:16] % 14);
		return {nib, r[15:2], 2'b00};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Checks

	task automatic abort_run(input string why);
		$display("test failed");
		$fatal(1, why);
	endtask

	task automatic check_word(input string name,
		input logic [fmc_apb_pkg::data_width-1:0] expected,
		input logic [fmc_apb_pkg::data_width-1:0] actual);
		if (actual !== expected) begin
			$display("ERR %s expected %08h actual %08h", name, expected, actual);
			$display("test failed");
			$fatal(1, "read word mismatch");
		end
	endtask

	task automatic check_ad(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected) begin
			$display("ERR %s expected %04h actual %04h", name, expected, actual);
			$display("test failed");
			$fatal(1, "read half word mismatch");
		end
	endtask

	// Single-bit FMC control outputs
	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERR %s expected %b actual %b", name, expected, actual);
			$display("test failed");
			$fatal(1, "control output mismatch");
		end
	endtask

	// Compare process, one finished read per clock
	always @(negedge apb) begin
		if (got_q.size() > 0) begin
			cmp_exp  = exp_q.pop_front();
			cmp_got  = got_q.pop_front();
			cmp_name = name_q.pop_front();
			check_word(cmp_name, cmp_exp, cmp_got);
			checked++;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// FMC master model

	// Drive point, a little after the rising edge
	task automatic next_cycle();
		@(posedge apb);
		#1;
	endtask

	// Deselect for two clocks
	task automatic end_access();
		next_cycle();
		cs_n   = 1'b1;
		nadv_n = 1'b1;
		nwe_n  = 1'b1;
		noe_n  = 1'b1;
		nbl_n  = 2'b11;
		ad_in  = '0;
		// Deselected bus never stalls and never drives the pads
		@(negedge apb);
		check_flag({test_name, " nwait while deselected"}, 1'b1, nwait);
		check_flag({test_name, " ad_oe_n while deselected"}, 1'b1, ad_oe_n);
		next_cycle();
	endtask

	task automatic fmc_write(input logic [19:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		int waited;
		int high_seen;
		// Address clock
		next_cycle();
		cs_n   = 1'b0;
		nadv_n = 1'b0;
		nwe_n  = 1'b0;
		noe_n  = 1'b1;
		nbl_n  = 2'b11;
		a_hi   = addr[19:17];
		ad_in  = addr[16:1];
		// Low half
		next_cycle();
		nadv_n = 1'b1;
		ad_in  = data[15:0];
		nbl_n  = ~strb[1:0];
		@(negedge apb);
		if (!nwait) begin
			// Repeat low half until nwait has been high for wait_rtt clocks
			waited    = 0;
			high_seen = 0;
			while (high_seen < wait_rtt) begin
				waited++;
				if (waited > wait_limit)
					abort_run("nwait stayed low during a write");
				next_cycle();
				@(negedge apb);
				if (nwait)
					high_seen++;
			end
		end
		// High half
		next_cycle();
		ad_in = data[31:16];
		nbl_n = ~strb[3:2];
		end_access();
		model_write(addr, data, strb);
	endtask

	task automatic fmc_read(input logic [19:0] addr);
		logic [31:0] expected;
		logic [15:0] lo;
		logic [15:0] hi;
		int          waited;
		expected = ref_read(addr);
		// Address clock
		next_cycle();
		cs_n   = 1'b0;
		nadv_n = 1'b0;
		nwe_n  = 1'b1;
		noe_n  = 1'b1;
		nbl_n  = 2'b00;
		a_hi   = addr[19:17];
		ad_in  = addr[16:1];
		next_cycle();
		nadv_n = 1'b1;
		noe_n  = 1'b0;
		ad_in  = '0;
		// Poll nwait mid-cycle until the bridge lets go
		waited = 0;
		@(negedge apb);
		check_flag({test_name, " ad_oe_n during read"}, 1'b0, ad_oe_n);
		while (!nwait) begin
			waited++;
			if (waited > wait_limit)
				abort_run("nwait stayed low during a read");
			next_cycle();
			@(negedge apb);
		end
		next_cycle();
		@(negedge apb);
		lo = ad_out;
		next_cycle();
		@(negedge apb);
		hi = ad_out;
		end_access();
		if (addr[19:16] > 4'h1)
			miss_model = (miss_model == '1) ? miss_model : miss_model + 32'd1;
		exp_q.push_back(expected);
		got_q.push_back({hi, lo});
		name_q.push_back(test_name);
		issued++;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests

	// Whole-run guard in case a wait loop itself never advances
	initial begin
		#500_000;
		$display("test failed");
		$fatal(1, "simulation ran far too long");
	end

	initial begin : main
		logic [19:0] a;
		logic [19:0] b2b_addr [4];
		logic [3:0]  strb_set [4];
		int          n;
		cs_n          = 1'b1;
		nadv_n        = 1'b1;
		nwe_n         = 1'b1;
		noe_n         = 1'b1;
		nbl_n         = 2'b11;
		a_hi          = '0;
		ad_in         = '0;
		issued        = 0;
		checked       = 0;
		scratch_model = '0;
		miss_model    = '0;
		strb_set      = '{4'b0001, 4'b1000, 4'b0110, 4'b1010};

		n = 0;
		while (!arst_n) begin
			n++;
			if (n > wait_limit)
				abort_run("reset never released");
			@(posedge apb);
		end

		// Data pins come out of reset cleared
		test_name = "reset";
		check_ad(test_name, 16'h0000, ad_out);
		end_access();

		// Full words to random RAM addresses
		test_name = "ram_full_word";
		repeat (8) begin
			a = pick_ram_addr();
			fmc_write(a, $random(seed), 4'hf);
			fmc_read(a);
		end

		// Byte lanes from nbl_n, untouched lanes keep old data
		test_name = "ram_partial";
		repeat (3) begin
			a = pick_ram_addr();
			fmc_write(a, $random(seed), 4'hf);
			for (int i = 0; i < 4; i++) begin
				fmc_write(a, $random(seed), strb_set[i]);
				fmc_read(a);
			end
		end

		// ID is fixed, scratch merges by lane, gaps read zero
		test_name = "status_regs";
		fmc_read(20'h1_0000);
		fmc_write(20'h1_0000, $random(seed), 4'hf);
		fmc_read(20'h1_0000);
		fmc_write(20'h1_0008, $random(seed), 4'hf);
		fmc_read(20'h1_0008);
		fmc_write(20'h1_0008, $random(seed), 4'b0101);
		fmc_read(20'h1_0008);
		fmc_write(20'h1_0008, $random(seed), 4'b1000);
		fmc_read(20'h1_0008);
		fmc_read(20'h1_000c);

		// Unmapped reads and writes, miss count after each
		test_name = "unmapped";
		fmc_read(20'h1_0004);
		for (int i = 0; i < 6; i++) begin
			a = pick_miss_addr();
			if (i % 2 == 0)
				fmc_read(a);
			else
				fmc_write(a, $random(seed), 4'hf);
			fmc_read(20'h1_0004);
		end

		// Minimum gaps, reads behind RAM writes stall on nwait
		test_name = "back_to_back";
		for (int i = 0; i < 4; i++) begin
			b2b_addr[i] = pick_ram_addr();
			fmc_write(b2b_addr[i], $random(seed), 4'hf);
		end
		for (int i = 0; i < 4; i++)
			fmc_read(b2b_addr[i]);
		repeat (6) begin
			a = pick_ram_addr();
			fmc_write(a, $random(seed), 4'hf);
			fmc_read(a);
		end

		// Let the compare process catch up
		n = 0;
		while (got_q.size() > 0 && n < wait_limit) begin
			n++;
			@(posedge apb);
		end
		@(posedge apb);

		if (checked == issued && got_q.size() == 0) begin
			$display("test passed");
			$finish;
		end else begin
			$display("test failed");
			$fatal(1, "some reads were never compared");
		end
	end

endmodule

//--- tb/fmc_clock_gen.sv
`timescale 1ns/1ps

// Free-running clock plus power-on reset for the testbench
module fmc_clock_gen #(
	parameter int period_ns    = 10,
	parameter int reset_cycles = 3
) (
	output logic apb,
	output logic arst_n
);

	initial begin
		apb = 1'b0;
		forever #(period_ns / 2) apb = ~apb;
	end

	// Release just after an edge, like every other driven input
	initial begin
		arst_n = 1'b0;
		repeat (reset_cycles) @(posedge apb);
		#1 arst_n = 1'b1;
	end

endmodule

//--- rtl/fmc_apb_top.sv
`timescale 1ns/1ps

module fmc_apb_top #(
	parameter bit early_read  = 1'b1,
	parameter int wait_rtt    = 2,
	parameter int depth_words = 256
) (
	input  logic        apb,
	input  logic        arst_n,
	input  logic        cs_n,
	input  logic        nadv_n,
	input  logic        nwe_n,
	input  logic        noe_n,
	input  logic [1:0]  nbl_n,
	input  logic [2:0]  a_hi,
	input  logic [15:0] ad_in,
	output logic [15:0] ad_out,
	output logic        ad_oe_n,
	output logic        nwait
);

	//////////////////////////////////////////////////////////////////////
	// Internal buses

	apb_if bus_root ();
	apb_if bus_ram ();

	// Status block side channel
	logic                                 status_sel;
	logic                                 status_write;
	logic [3:0]                           status_addr;
	logic [fmc_apb_pkg::data_width/8-1:0] status_strb;
	logic [fmc_apb_pkg::data_width-1:0]   status_wdata;
	logic [fmc_apb_pkg::data_width-1:0]   status_rdata;
	logic                                 miss;

	// Pad driver enable mirrors the MCU output enable
	assign ad_oe_n = noe_n;

	//////////////////////////////////////////////////////////////////////
	// FMC side

	fmc_apb_bridge #(
		.early_read (early_read),
		.wait_rtt   (wait_rtt)
	) u_bridge (
		.apb    (apb),
		.arst_n (arst_n),
		.cs_n   (cs_n),
		.nadv_n (nadv_n),
		.nwe_n  (nwe_n),
		.nbl_n  (nbl_n),
		.a_hi   (a_hi),
		.ad_in  (ad_in),
		.ad_out (ad_out),
		.nwait  (nwait),
		.bus    (bus_root)
	);

	//////////////////////////////////////////////////////////////////////
	// Interconnect and completers

	apb_decoder u_decoder (
		.bus_root     (bus_root),
		.bus_ram      (bus_ram),
		.status_sel   (status_sel),
		.status_write (status_write),
		.status_addr  (status_addr),
		.status_strb  (status_strb),
		.status_wdata (status_wdata),
		.status_rdata (status_rdata),
		.miss         (miss)
	);

	apb_scratch_ram #(
		.depth_words (depth_words)
	) u_ram (
		.apb    (apb),
		.arst_n (arst_n),
		.bus    (bus_ram)
	);

	apb_status_regs u_status (
		.apb    (apb),
		.arst_n (arst_n),
		.sel    (status_sel),
		.write  (status_write),
		.addr   (status_addr),
		.strb   (status_strb),
		.wdata  (status_wdata),
		.rdata  (status_rdata),
		.miss   (miss)
	);

endmodule

//--- rtl/apb_status_regs.sv
`timescale 1ns/1ps

module apb_status_regs (
	input  logic                                  apb,
	input  logic                                  arst_n,
	input  logic                                  sel,
	input  logic                                  write,
	input  logic [3:0]                            addr,
	input  logic [fmc_apb_pkg::data_width/8-1:0]  strb,
	input  logic [fmc_apb_pkg::data_width-1:0]    wdata,
	output logic [fmc_apb_pkg::data_width-1:0]    rdata,
	input  logic                                  miss
);

	logic [fmc_apb_pkg::data_width-1:0] miss_count;
	logic [fmc_apb_pkg::data_width-1:0] scratch;
	logic                               scratch_we;

	// Only the scratch word is writable, id and miss count ignore writes
	assign scratch_we = sel && write && (addr == fmc_apb_pkg::reg_scratch);

	always_ff @(posedge apb or negedge arst_n) begin
		if (!arst_n) begin
			miss_count <= '0;
			scratch    <= '0;
		end else begin
			// Saturate at all ones
			if (miss && miss_count != '1)
				miss_count <= miss_count + 1'b1;

			if (scratch_we) begin
				for (int b = 0; b < fmc_apb_pkg::data_width / 8; b++) begin
					if (strb[b])
						scratch[8*b +: 8] <= wdata[8*b +: 8];
				end
			end
		end
	end

	// Read mux, ready in the same cycle
	always_comb begin
		case (addr)
			fmc_apb_pkg::reg_id:         rdata = fmc_apb_pkg::id_value;
			fmc_apb_pkg::reg_miss_count: rdata = miss_count;
			fmc_apb_pkg::reg_scratch:    rdata = scratch;
			default:                     rdata = '0;
		endcase
	end

endmodule

//--- rtl/apb_scratch_ram.sv
`timescale 1ns/1ps

module apb_scratch_ram #(
	parameter int depth_words = 256
) (
	input  logic     apb,
	input  logic     arst_n,
	apb_if.completer bus
);

	// Depth is a power of two, address bits wrap modulo the depth
	localparam int idx_w   = $clog2(depth_words);
	localparam int n_bytes = fmc_apb_pkg::data_width / 8;

	logic [fmc_apb_pkg::data_width-1:0] mem [depth_words];
	logic [idx_w-1:0]                   idx;
	logic                               rdy;
	logic                               access;

	// Word index, byte offset bits dropped
	assign idx    = bus.paddr[idx_w+1:2];
	assign access = bus.psel && bus.penable;

	//////////////////////////////////////////////////////////////////////
	// Wait state

	// First access cycle sets the flag, completion clears it again
	always_ff @(posedge apb or negedge arst_n) begin
		if (!arst_n)
			rdy <= 1'b0;
		else if (access && !rdy)
			rdy <= 1'b1;
		else
			rdy <= 1'b0;
	end

	assign bus.pready = rdy;

	//////////////////////////////////////////////////////////////////////
	// Storage

	always_ff @(posedge apb) begin
		// Read data registered during the wait state
		if (access && !rdy)
			bus.prdata <= mem[idx];

		// Byte-merged write on the completing edge
		if (access && rdy && bus.pwrite) begin
			for (int b = 0; b < n_bytes; b++) begin
				if (bus.pstrb[b])
					mem[idx][8*b +: 8] <= bus.pwdata[8*b +: 8];
			end
		end
	end

endmodule

//--- rtl/apb_decoder.sv
`timescale 1ns/1ps

module apb_decoder (
	apb_if.completer                          bus_root,
	apb_if.requester                          bus_ram,
	output logic                              status_sel,
	output logic                              status_write,
	output logic [3:0]                        status_addr,
	output logic [fmc_apb_pkg::data_width/8-1:0] status_strb,
	output logic [fmc_apb_pkg::data_width-1:0]   status_wdata,
	input  logic [fmc_apb_pkg::data_width-1:0]   status_rdata,
	output logic                              miss
);

	fmc_apb_pkg::region_t region;
	logic                 access;

	// Top nibble of the byte address picks the completer
	always_comb begin
		case (bus_root.paddr[fmc_apb_pkg::addr_width-1 -: 4])
			4'h0:    region = fmc_apb_pkg::region_ram;
			4'h1:    region = fmc_apb_pkg::region_status;
			default: region = fmc_apb_pkg::region_miss;
		endcase
	end

	assign access = bus_root.psel && bus_root.penable;

	// RAM sees the full request, psel only when addressed
	assign bus_ram.paddr   = bus_root.paddr;
	assign bus_ram.pwrite  = bus_root.pwrite;
	assign bus_ram.psel    = bus_root.psel && (region == fmc_apb_pkg::region_ram);
	assign bus_ram.penable = bus_root.penable;
	assign bus_ram.pstrb   = bus_root.pstrb;
	assign bus_ram.pwdata  = bus_root.pwdata;

	// Status block acts in the access phase only
	assign status_sel   = access && (region == fmc_apb_pkg::region_status);
	assign status_write = bus_root.pwrite;
	assign status_addr  = bus_root.paddr[3:0];
	assign status_strb  = bus_root.pstrb;
	assign status_wdata = bus_root.pwdata;

	// Unmapped access completes at once, so this is the completing cycle
	assign miss = access && (region == fmc_apb_pkg::region_miss);

	// Response mux
	always_comb begin
		case (region)
			fmc_apb_pkg::region_ram: begin
				bus_root.prdata = bus_ram.prdata;
				bus_root.pready = bus_ram.pready;
			end
			fmc_apb_pkg::region_status: begin
				bus_root.prdata = status_rdata;
				bus_root.pready = 1'b1;
			end
			default: begin
				bus_root.prdata = fmc_apb_pkg::miss_rdata;
				bus_root.pready = 1'b1;
			end
		endcase
	end

endmodule

//--- rtl/fmc_apb_bridge.sv
`timescale 1ns/1ps

module fmc_apb_bridge #(
	parameter bit early_read = 1'b0,
	parameter int wait_rtt   = 2
) (
	input  logic        apb,
	input  logic        arst_n,
	input  logic        cs_n,
	input  logic        nadv_n,
	input  logic        nwe_n,
	input  logic [1:0]  nbl_n,
	input  logic [2:0]  a_hi,
	input  logic [15:0] ad_in,
	output logic [15:0] ad_out,
	output logic        nwait,
	apb_if.requester    bus
);

	// Last count value of the post-stall delay
	localparam logic [3:0] rtt_last = 4'(wait_rtt - 1);

	fmc_apb_pkg::bridge_state_t state;

	logic [3:0]                              wait_count;
	logic [fmc_apb_pkg::addr_width-1:0]      cap_addr;
	logic [fmc_apb_pkg::addr_width-1:0]      pending_addr;
	logic [15:0]                             wdata_lo;
	logic [1:0]                              strb_lo;
	logic [fmc_apb_pkg::data_width-1:0]      prdata_latched;
	logic                                    busy;
	logic                                    xfer_done;
	logic                                    early_done;
	logic                                    addr_take;
	logic                                    rd_issue;
	logic                                    lo_take;
	logic                                    hi_take;

	//////////////////////////////////////////////////////////////////////
	// Transfer tracking

	// One transfer in flight, so psel doubles as the busy flag
	assign busy      = bus.psel;
	assign xfer_done = bus.psel && bus.penable && bus.pready;

	// Read finishing right now with low half forwarded straight from prdata
	assign early_done = early_read && xfer_done &&
		(state == fmc_apb_pkg::st_rdata_lo);

	// LSB always zero, bus is 16 bits wide
	assign cap_addr = {a_hi, ad_in, 1'b0};

	// Address clock seen
	assign addr_take = !cs_n && !nadv_n &&
		(state == fmc_apb_pkg::st_idle || state == fmc_apb_pkg::st_addr);

	// Reads go out at once if the bus is free, else after the stall
	assign rd_issue = (addr_take && nwe_n && !busy) ||
		(!cs_n && state == fmc_apb_pkg::st_wait && !busy);

	// Low half is repeated by the MCU during a stall, keep resampling it
	assign lo_take = !cs_n &&
		(state == fmc_apb_pkg::st_wdata_lo || state == fmc_apb_pkg::st_wdata_wait);
	assign hi_take = !cs_n && state == fmc_apb_pkg::st_wdata_hi;

	// Stall while anything is pending, or while a read is held back
	always_comb begin
		if (cs_n)
			nwait = 1'b1;
		else if (early_done)
			nwait = 1'b1;
		else
			nwait = !(busy || state == fmc_apb_pkg::st_wait);
	end

	//////////////////////////////////////////////////////////////////////
	// Payload registers

	always_ff @(posedge apb) begin
		if (addr_take)
			pending_addr <= cap_addr;

		// Staged apart from pwdata so an in-flight write stays stable
		if (lo_take) begin
			wdata_lo <= ad_in;
			strb_lo  <= ~nbl_n;
		end

		if (rd_issue) begin
			// Fresh address on the fast path, saved one after a stall
			bus.paddr  <= addr_take ? cap_addr : pending_addr;
			bus.pwrite <= 1'b0;
			bus.pstrb  <= '0;
		end

		if (hi_take) begin
			bus.paddr  <= pending_addr;
			bus.pwrite <= 1'b1;
			bus.pstrb  <= {~nbl_n, strb_lo};
			bus.pwdata <= {ad_in, wdata_lo};
		end

		if (xfer_done)
			prdata_latched <= bus.prdata;
	end

	//////////////////////////////////////////////////////////////////////
	// APB phases and FMC state machine

	always_ff @(posedge apb or negedge arst_n) begin
		if (!arst_n) begin
			state       <= fmc_apb_pkg::st_idle;
			bus.psel    <= 1'b0;
			bus.penable <= 1'b0;
			wait_count  <= '0;
			ad_out      <= '0;
		end else begin
			// Setup phase lasts one cycle, access phase until pready
			if (xfer_done) begin
				bus.psel    <= 1'b0;
				bus.penable <= 1'b0;
			end else if (bus.psel) begin
				bus.penable <= 1'b1;
			end

			// New transfer enters setup phase
			if (rd_issue || hi_take)
				bus.psel <= 1'b1;

			// Deselect ends the access wherever it was
			if (cs_n) begin
				state <= fmc_apb_pkg::st_idle;
			end else begin
				case (state)

					// Wait for the address clock
					fmc_apb_pkg::st_idle, fmc_apb_pkg::st_addr: begin
						if (nadv_n)
							state <= fmc_apb_pkg::st_addr;
						else if (!nwe_n)
							state <= fmc_apb_pkg::st_wdata_lo;
						else if (busy)
							state <= fmc_apb_pkg::st_wait;
						else
							state <= fmc_apb_pkg::st_rdata_lo;
					end

					// Read held back behind the previous transfer
					fmc_apb_pkg::st_wait: begin
						if (!busy)
							state <= fmc_apb_pkg::st_rdata_lo;
					end

					// Write path
					fmc_apb_pkg::st_wdata_lo: begin
						if (!nwait) begin
							state      <= fmc_apb_pkg::st_wdata_wait;
							wait_count <= '0;
						end else begin
							state <= fmc_apb_pkg::st_wdata_hi;
						end
					end

					// MCU needs wait_rtt clocks of nwait high before the high half
					fmc_apb_pkg::st_wdata_wait: begin
						if (nwait) begin
							wait_count <= wait_count + 4'd1;
							if (wait_count == rtt_last)
								state <= fmc_apb_pkg::st_wdata_hi;
						end
					end

					fmc_apb_pkg::st_wdata_hi: begin
						state <= fmc_apb_pkg::st_active;
					end

					// Read path
					fmc_apb_pkg::st_rdata_lo: begin
						if (early_done) begin
							ad_out <= bus.prdata[15:0];
							state  <= fmc_apb_pkg::st_rdata_hi;
						end else if (!busy) begin
							ad_out <= prdata_latched[15:0];
							state  <= fmc_apb_pkg::st_rdata_hi;
						end
					end

					fmc_apb_pkg::st_rdata_hi: begin
						ad_out <= prdata_latched[31:16];
						state  <= fmc_apb_pkg::st_rd_end;
					end

					// Ignore the bus until cs_n goes high
					fmc_apb_pkg::st_rd_end, fmc_apb_pkg::st_active: begin
						state <= state;
					end

					default: begin
						state <= fmc_apb_pkg::st_idle;
					end

				endcase
			end
		end
	end

endmodule

//--- rtl/apb_if.sv
`timescale 1ns/1ps

// APB bus between bridge, decoder and completers
// Clock and reset travel as plain ports, not through here
interface apb_if;

	// Request side
	logic [fmc_apb_pkg::addr_width-1:0]   paddr;
	logic                                 pwrite;
	logic                                 psel;
	logic                                 penable;
	logic [fmc_apb_pkg::data_width/8-1:0] pstrb;
	logic [fmc_apb_pkg::data_width-1:0]   pwdata;

	// Response side
	logic [fmc_apb_pkg::data_width-1:0]   prdata;
	logic                                 pready;

	// Initiator of transfers
	modport requester (
		output paddr, pwrite, psel, penable, pstrb, pwdata,
		input  prdata, pready
	);

	// Target of transfers
	modport completer (
		input  paddr, pwrite, psel, penable, pstrb, pwdata,
		output prdata, pready
	);

endinterface

//--- rtl/fmc_apb_pkg.sv
package fmc_apb_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus geometry

	// Byte address: 3 high pins, 16 muxed bits, implicit zero LSB
	localparam int addr_width = 20;
	localparam int data_width = 32;

	//////////////////////////////////////////////////////////////////////
	// Address map, selected by paddr[19:16]

	// Anything other than ram or status lands on the miss responder
	typedef enum logic [1:0] {
		region_ram    = 2'd0,
		region_status = 2'd1,
		region_miss   = 2'd2
	} region_t;

	// Word offsets inside the status block
	typedef enum logic [3:0] {
		reg_id         = 4'h0,
		reg_miss_count = 4'h4,
		reg_scratch    = 4'h8
	} status_reg_t;

	// Fixed contents
	localparam logic [data_width-1:0] id_value   = 32'h464d_4331;
	localparam logic [data_width-1:0] miss_rdata = 32'hbad0_0bad;

	//////////////////////////////////////////////////////////////////////
	// Bridge FSM states

	typedef enum logic [3:0] {
		st_idle,
		st_addr,
		st_wait,
		st_wdata_lo,
		st_wdata_wait,
		st_wdata_hi,
		st_rdata_lo,
		st_rdata_hi,
		st_rd_end,
		st_active
	} bridge_state_t;

endpackage
